//--- project.f
rtl/mips_isa_pkg.sv
rtl/mips_core_pkg.sv
rtl/mips_alu.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_pc_unit.sv
rtl/mips_control.sv
rtl/mips_cpu_bus.sv
sim/tb_clock.sv
sim/mips_cpu_bus_assertions.sv
sim/tb_mips_cpu_bus.sv

//--- run.sh
#!/bin/sh
# Build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_mips_cpu_bus -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

//--- sim/tb_mips_cpu_bus.sv
// ****************************************
// Testbench of the multicycle MIPS core
// Memory model, program builder, reference
// interpreter and the list of tests
// ****************************************

`timescale 1ns/1ps

module tb_mips_cpu_bus;

    localparam logic [31:0] code_base = 32'hBFC0_0000;
    localparam logic [31:0] data_base = 32'h0000_0100;

    logic clk;
    logic reset;
    logic waitrequest = 1'b0;
    logic rand_wait = 1'b0;
    logic [31:0] rng = 32'd43109;
    logic [31:0] readdata;
    logic active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic read;
    logic write;
    logic [3:0] byteenable;

    // Code at the reset vector, data words from 0x100
    logic [31:0] code_mem [256];
    logic [31:0] data_mem [64];
    logic [31:0] exp_data [64];
    logic [31:0] prog [$];

    int tests_run = 0;
    int tests_failed = 0;
    int errors = 0;
    int test_errors;

    tb_clock #(.half_period_ns(20)) u_clock (.clk(clk));

    mips_cpu_bus u_dut (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Background content of unwritten words
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] rtype_word(int fn, int rs, int rt, int rd, int sh);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] itype_word(int op, int rs, int rt, int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // J to a word index of the program
    function automatic logic [31:0] jump_word(int index);
        logic [31:0] dest;
        dest = code_base + 32'(index * 4);
        return {6'd2, dest[27:2]};
    endfunction

    // Combinational read data
    always_comb begin
        readdata = 32'h0;
        if (address[31:10] == code_base[31:10]) begin
            readdata = code_mem[address[9:2]];
        end else if (address[31:8] == data_base[31:8]) begin
            readdata = data_mem[address[7:2]];
        end
    end

    // Writes land at the edge where the request is accepted
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                data_mem[i] <= fill_word(data_base + 32'(i * 4));
            end
        end else if (write && !waitrequest && address[31:8] == data_base[31:8]) begin
            data_mem[address[7:2]] <= writedata;
        end
    end

    // Wait states, random when enabled
    always @(posedge clk) begin
        if (rand_wait) begin
            rng <= xorshift32(rng);
            waitrequest <= rng[0] ^ rng[7];
        end else begin
            waitrequest <= 1'b0;
        end
    end

    // Interprets the code image, returns $v0 and fills exp_data
    function automatic logic [31:0] ref_run();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] ins;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] addr;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sh;
        int steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = 32'h0;
        end
        for (int i = 0; i < 64; i++) begin
            exp_data[i] = fill_word(data_base + 32'(i * 4));
        end
        pc = code_base;
        steps = 0;
        while (pc != 32'h0 && steps < 10000) begin
            ins = code_mem[pc[9:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            sh = ins[10:6];
            sext = {{16{ins[15]}}, ins[15:0]};
            zext = {16'h0, ins[15:0]};
            addr = r[rs] + sext;
            npc = pc + 32'd4;
            case (ins[31:26])
                6'd0: begin
                    case (ins[5:0])
                        6'd33: r[rd] = r[rs] + r[rt];
                        6'd35: r[rd] = r[rs] - r[rt];
                        6'd36: r[rd] = r[rs] & r[rt];
                        6'd37: r[rd] = r[rs] | r[rt];
                        6'd38: r[rd] = r[rs] ^ r[rt];
                        6'd42: r[rd] = {31'h0, $signed(r[rs]) < $signed(r[rt])};
                        6'd43: r[rd] = {31'h0, r[rs] < r[rt]};
                        6'd0: r[rd] = r[rt] << sh;
                        6'd2: r[rd] = r[rt] >> sh;
                        6'd3: r[rd] = $signed(r[rt]) >>> sh;
                        6'd8: npc = r[rs];
                        default: ;
                    endcase
                end
                6'd9: r[rt] = addr;
                6'd10: r[rt] = {31'h0, $signed(r[rs]) < $signed(sext)};
                6'd11: r[rt] = {31'h0, r[rs] < sext};
                6'd12: r[rt] = r[rs] & zext;
                6'd13: r[rt] = r[rs] | zext;
                6'd14: r[rt] = r[rs] ^ zext;
                6'd15: r[rt] = {ins[15:0], 16'h0};
                6'd35: begin
                    if (addr[31:8] == data_base[31:8]) begin
                        r[rt] = exp_data[addr[7:2]];
                    end else if (addr[31:10] == code_base[31:10]) begin
                        r[rt] = code_mem[addr[9:2]];
                    end else begin
                        r[rt] = 32'h0;
                    end
                end
                6'd43: begin
                    if (addr[31:8] == data_base[31:8]) begin
                        exp_data[addr[7:2]] = r[rt];
                    end
                end
                6'd4: if (r[rs] == r[rt]) npc = pc + 32'd4 + (sext << 2);
                6'd5: if (r[rs] != r[rt]) npc = pc + 32'd4 + (sext << 2);
                6'd2: npc = {npc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            r[0] = 32'h0;
            pc = npc;
            steps++;
        end
        return r[2];
    endfunction

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            code_mem[i] = (i < prog.size()) ? prog[i] : fill_word(code_base + 32'(i * 4));
        end
    endtask

    // Every ALU op, folded into $v0
    task automatic build_alu();
        prog.delete();
        prog.push_back(itype_word(15, 0, 8, 16'h1234));
        prog.push_back(itype_word(13, 8, 8, 16'h5678));
        prog.push_back(itype_word(9, 0, 9, -3));
        prog.push_back(rtype_word(33, 8, 9, 10, 0));
        prog.push_back(rtype_word(35, 9, 8, 11, 0));
        prog.push_back(rtype_word(36, 8, 9, 12, 0));
        prog.push_back(rtype_word(37, 8, 9, 13, 0));
        prog.push_back(rtype_word(38, 8, 9, 14, 0));
        prog.push_back(rtype_word(42, 9, 8, 15, 0));
        prog.push_back(rtype_word(43, 9, 8, 16, 0));
        prog.push_back(rtype_word(0, 0, 8, 17, 4));
        prog.push_back(rtype_word(2, 0, 9, 18, 3));
        prog.push_back(rtype_word(3, 0, 9, 19, 3));
        prog.push_back(itype_word(12, 9, 20, 16'hF0F0));
        prog.push_back(itype_word(14, 8, 21, 16'hFFFF));
        prog.push_back(itype_word(10, 9, 22, -1));
        prog.push_back(itype_word(11, 8, 23, 16'hFFFF));
        // Write to $zero must be lost
        prog.push_back(itype_word(9, 0, 0, 5));
        for (int k = 10; k <= 23; k++) begin
            prog.push_back(rtype_word(33, 2, k, 2, 0));
            prog.push_back(rtype_word(0, 0, 2, 2, 1));
        end
        prog.push_back(rtype_word(33, 2, 0, 2, 0));
        prog.push_back(rtype_word(8, 0, 0, 0, 0));
    endtask

    // Stores then loads back, sum stored too
    task automatic build_mem();
        prog.delete();
        prog.push_back(itype_word(9, 0, 8, 16'h0100));
        prog.push_back(itype_word(9, 0, 9, 7));
        prog.push_back(itype_word(43, 8, 9, 0));
        prog.push_back(itype_word(9, 9, 9, 16'h0011));
        prog.push_back(itype_word(43, 8, 9, 4));
        prog.push_back(itype_word(9, 8, 10, 16));
        prog.push_back(itype_word(43, 10, 9, -4));
        prog.push_back(itype_word(35, 8, 11, 0));
        prog.push_back(itype_word(35, 8, 12, 4));
        prog.push_back(itype_word(35, 8, 13, 12));
        prog.push_back(itype_word(35, 8, 14, 32));
        prog.push_back(rtype_word(33, 11, 12, 2, 0));
        prog.push_back(rtype_word(33, 2, 13, 2, 0));
        prog.push_back(rtype_word(38, 2, 14, 2, 0));
        prog.push_back(itype_word(43, 8, 2, 20));
        prog.push_back(rtype_word(8, 0, 0, 0, 0));
    endtask

    // Loops, branches both ways and J
    task automatic build_flow();
        prog.delete();
        prog.push_back(itype_word(9, 0, 8, 5));
        prog.push_back(itype_word(9, 2, 2, 3));
        prog.push_back(itype_word(9, 8, 8, -1));
        prog.push_back(itype_word(5, 8, 0, -3));
        prog.push_back(itype_word(4, 8, 0, 1));
        prog.push_back(itype_word(9, 2, 2, 100));
        prog.push_back(itype_word(4, 2, 0, 1));
        prog.push_back(itype_word(9, 2, 2, 7));
        prog.push_back(itype_word(5, 2, 2, 1));
        prog.push_back(jump_word(11));
        prog.push_back(itype_word(9, 2, 2, 1000));
        prog.push_back(itype_word(14, 2, 2, 16'h0055));
        prog.push_back(itype_word(9, 0, 9, 2));
        prog.push_back(itype_word(9, 2, 2, 1));
        prog.push_back(itype_word(9, 9, 9, -1));
        prog.push_back(itype_word(4, 9, 0, 1));
        prog.push_back(jump_word(13));
        prog.push_back(rtype_word(8, 0, 0, 0, 0));
    endtask

    task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        test_errors++;
    endtask

    // Reset, run to halt, check bus idle and results
    task automatic run_test(string name, logic stall);
        logic [31:0] exp_v0;
        int n;
        test_errors = 0;
        load_program();
        @(posedge clk);
        reset <= 1'b1;
        rand_wait <= stall;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (read || write) begin
                $display("Bus access seen while reset was high");
                test_errors++;
            end
        end
        @(posedge clk);
        reset <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(read || write) && n < 50);
        if (!read) begin
            $display("First access after reset was not a read");
            test_errors++;
        end
        if (address != code_base) begin
            fail_value("address", address, code_base);
        end
        n = 0;
        while (active && n < 5000) begin
            @(negedge clk);
            n++;
            // Every access is a whole word
            if ((read || write) && byteenable != 4'hF) begin
                fail_value("byteenable", {28'h0, byteenable}, 32'h0000_000F);
            end
        end
        if (active) begin
            $display("Timeout waiting for the core to halt");
            test_errors++;
        end else begin
            for (int c = 0; c < 20; c++) begin
                @(negedge clk);
                if (read || write || active) begin
                    $display("Bus activity after the core halted");
                    test_errors++;
                end
            end
            exp_v0 = ref_run();
            if (register_v0 != exp_v0) begin
                fail_value("register_v0", register_v0, exp_v0);
            end
            for (int i = 0; i < 64; i++) begin
                if (data_mem[i] != exp_data[i]) begin
                    fail_value($sformatf("data_mem[%0d]", i), data_mem[i], exp_data[i]);
                end
            end
        end
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-16s %s", name, (test_errors == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        reset = 1'b1;
        build_alu();
        run_test("alu", 1'b0);
        build_mem();
        run_test("memory", 1'b0);
        build_flow();
        run_test("control_flow", 1'b0);
        build_alu();
        run_test("alu_stall", 1'b1);
        build_mem();
        run_test("memory_stall", 1'b1);
        build_flow();
        run_test("flow_stall", 1'b1);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sim/mips_cpu_bus_assertions.sv
// ****************************************
// Bus-protocol checks for the MIPS core
// Bound to every mips_cpu_bus instance
// ****************************************

`timescale 1ns/1ps

module mips_cpu_bus_assertions (
    input logic clk,
    input logic reset,
    input logic active,
    input logic read,
    input logic write,
    input logic waitrequest,
    input logic [31:0] address,
    input logic [31:0] writedata
);

    // One access kind at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write high in the same cycle");

    // A stalled request stays put until accepted
    hold_under_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable({address, read, write, writedata}))
        else $error("bus request changed while waitrequest was high");

    // Idle core never touches the bus
    idle_when_inactive: assert property (@(posedge clk)
        !active |-> !(read || write))
        else $error("bus access while active was low");

endmodule

bind mips_cpu_bus mips_cpu_bus_assertions u_bus_assertions (
    .clk(clk),
    .reset(reset),
    .active(active),
    .read(read),
    .write(write),
    .waitrequest(waitrequest),
    .address(address),
    .writedata(writedata)
);

//--- sim/tb_clock.sv
// ****************************************
// Free-running testbench clock
// Half period is set by a parameter
// ****************************************

`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period_ns = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(half_period_ns) clk = ~clk;

endmodule

//--- rtl/mips_cpu_bus.sv
// **************************************
// Multicycle MIPS I core with one
// Avalon-style memory master port
// Instantiate with reset_vector set to
// the address of the first instruction
// **************************************

`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter mips_isa_pkg::word_t reset_vector = mips_core_pkg::default_reset_vector
) (
    input  logic clk,
    input  logic reset,
    output logic active,
    output mips_isa_pkg::word_t register_v0,

    // Memory master
    output mips_isa_pkg::word_t address,
    output logic write,
    output logic read,
    input  logic waitrequest,
    output mips_isa_pkg::word_t writedata,
    output logic [3:0] byteenable,
    input  mips_isa_pkg::word_t readdata
);

    mips_isa_pkg::instr_u instr;
    mips_core_pkg::ctrl_t ctrl;
    mips_core_pkg::bus_req_t bus_req;
    mips_core_pkg::reg_wb_t wb;
    mips_isa_pkg::word_t rs_value;
    mips_isa_pkg::word_t rt_value;
    mips_isa_pkg::word_t alu_result;
    mips_isa_pkg::word_t pc;
    logic update;

    // Request bundle onto the bus pins
    assign address = bus_req.address;
    assign read = bus_req.read;
    assign write = bus_req.write;
    assign writedata = bus_req.writedata;

    // Word accesses only
    assign byteenable = 4'b1111;

    mips_control u_control (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .ctrl(ctrl),
        .alu_result(alu_result),
        .rt_value(rt_value),
        .pc(pc),
        .instr(instr),
        .bus_req(bus_req),
        .wb(wb),
        .update(update),
        .active(active)
    );

    mips_decoder u_decoder (
        .instr(instr),
        .ctrl(ctrl)
    );

    mips_regfile u_regfile (
        .clk(clk),
        .reset(reset),
        .rs_idx(instr.i.rs),
        .rt_idx(instr.i.rt),
        .wb(wb),
        .rs_value(rs_value),
        .rt_value(rt_value),
        .v0(register_v0)
    );

    mips_alu u_alu (
        .ctrl(ctrl),
        .instr(instr),
        .rs_value(rs_value),
        .rt_value(rt_value),
        .result(alu_result)
    );

    mips_pc_unit #(
        .reset_vector(reset_vector)
    ) u_pc_unit (
        .clk(clk),
        .reset(reset),
        .update(update),
        .ctrl(ctrl),
        .instr(instr),
        .rs_value(rs_value),
        .rt_value(rt_value),
        .pc(pc)
    );

endmodule

//--- rtl/mips_control.sv
// **************************************
// Sequencer of the multicycle core
// Runs fetch, execute and memory states,
// holds the instruction register and
// builds bus requests and write-backs
// **************************************

`timescale 1ns/1ps

module mips_control (
    input  logic clk,
    input  logic reset,
    input  logic waitrequest,
    input  mips_isa_pkg::word_t readdata,
    input  mips_core_pkg::ctrl_t ctrl,
    input  mips_isa_pkg::word_t alu_result,
    input  mips_isa_pkg::word_t rt_value,
    input  mips_isa_pkg::word_t pc,
    output mips_isa_pkg::instr_u instr,
    output mips_core_pkg::bus_req_t bus_req,
    output mips_core_pkg::reg_wb_t wb,
    output logic update,
    output logic active
);

    mips_core_pkg::state_t state;
    logic pc_is_zero;
    logic mem_access;

    // A jump to address zero ends the program
    assign pc_is_zero = (pc == '0);
    assign mem_access = ctrl.is_load | ctrl.is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_core_pkg::st_fetch;
        end else begin
            case (state)
                mips_core_pkg::st_fetch: begin
                    if (pc_is_zero) begin
                        state <= mips_core_pkg::st_halted;
                    end else if (!waitrequest) begin
                        state <= mips_core_pkg::st_execute;
                    end
                end
                mips_core_pkg::st_execute: begin
                    // Loads and stores need a data access
                    state <= mem_access ? mips_core_pkg::st_memory : mips_core_pkg::st_fetch;
                end
                mips_core_pkg::st_memory: begin
                    if (!waitrequest) begin
                        state <= mips_core_pkg::st_fetch;
                    end
                end
                default: begin
                    state <= mips_core_pkg::st_halted;
                end
            endcase
        end
    end

    // Instruction register, loads when the fetch read completes
    always_ff @(posedge clk) begin
        if (state == mips_core_pkg::st_fetch && !pc_is_zero && !waitrequest) begin
            instr <= readdata;
        end
    end

    // Request depends only on state and stable operands, so it holds under waitrequest
    always_comb begin
        bus_req = '0;
        case (state)
            mips_core_pkg::st_fetch: begin
                bus_req.address = pc;
                bus_req.read = !pc_is_zero;
            end
            mips_core_pkg::st_memory: begin
                bus_req.address = alu_result;
                bus_req.read = ctrl.is_load;
                bus_req.write = ctrl.is_store;
                bus_req.writedata = rt_value;
            end
            default: begin
                bus_req.address = pc;
            end
        endcase
        // Bus stays idle during reset
        if (reset) begin
            bus_req.read = 1'b0;
            bus_req.write = 1'b0;
        end
    end

    // ALU results retire in execute, load data in the last memory cycle
    always_comb begin
        wb.enable = 1'b0;
        wb.index = ctrl.dest;
        wb.data = alu_result;
        if (state == mips_core_pkg::st_execute) begin
            wb.enable = ctrl.reg_write & !ctrl.is_load;
        end else if (state == mips_core_pkg::st_memory) begin
            wb.enable = ctrl.is_load & !waitrequest;
            wb.data = readdata;
        end
    end

    // PC advances once per instruction
    assign update = (state == mips_core_pkg::st_execute);

    assign active = !reset && (state != mips_core_pkg::st_halted)
                    && !(state == mips_core_pkg::st_fetch && pc_is_zero);

endmodule

//--- rtl/mips_pc_unit.sv
// **************************************
// Program counter and next-PC logic
// Loads the next PC on the update strobe;
// no delay slot, offsets from PC+4
// **************************************

`timescale 1ns/1ps

module mips_pc_unit #(
    parameter mips_isa_pkg::word_t reset_vector = mips_core_pkg::default_reset_vector
) (
    input  logic clk,
    input  logic reset,
    input  logic update,
    input  mips_core_pkg::ctrl_t ctrl,
    input  mips_isa_pkg::instr_u instr,
    input  mips_isa_pkg::word_t rs_value,
    input  mips_isa_pkg::word_t rt_value,
    output mips_isa_pkg::word_t pc
);

    mips_isa_pkg::word_t pc_plus4;
    mips_isa_pkg::word_t branch_target;
    mips_isa_pkg::word_t jump_target;
    logic taken;

    assign pc_plus4 = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

    // J stays inside the current 256 MB region
    assign jump_target = {pc_plus4[31:28], instr.j.target, 2'b00};

    assign taken = (ctrl.branch == mips_core_pkg::br_beq && rs_value == rt_value)
                   || (ctrl.branch == mips_core_pkg::br_bne && rs_value != rt_value);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_vector;
        end else if (update) begin
            if (ctrl.is_jr) begin
                pc <= rs_value;
            end else if (ctrl.is_jump) begin
                pc <= jump_target;
            end else if (taken) begin
                pc <= branch_target;
            end else begin
                pc <= pc_plus4;
            end
        end
    end

endmodule

//--- rtl/mips_regfile.sv
// **************************************
// 32 x 32-bit register file
// Two combinational read ports, one write
// port; $zero reads zero, $v0 is exposed
// **************************************

`timescale 1ns/1ps

module mips_regfile (
    input  logic clk,
    input  logic reset,
    input  mips_isa_pkg::reg_idx_t rs_idx,
    input  mips_isa_pkg::reg_idx_t rt_idx,
    input  mips_core_pkg::reg_wb_t wb,
    output mips_isa_pkg::word_t rs_value,
    output mips_isa_pkg::word_t rt_value,
    output mips_isa_pkg::word_t v0
);

    mips_isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.enable && wb.index != mips_isa_pkg::reg_zero) begin
            // $zero never gets written so it keeps its reset value
            regs[wb.index] <= wb.data;
        end
    end

    assign rs_value = regs[rs_idx];
    assign rt_value = regs[rt_idx];

    // Result register seen by the testbench
    assign v0 = regs[mips_isa_pkg::reg_v0];

endmodule

//--- rtl/mips_decoder.sv
// **************************************
// Instruction decoder
// Maps the fetched word to the control
// bundle; unknown encodings act as no-ops
// **************************************

`timescale 1ns/1ps

module mips_decoder (
    input  mips_isa_pkg::instr_u instr,
    output mips_core_pkg::ctrl_t ctrl
);

    always_comb begin
        // No-op bundle, PC+4 only
        ctrl = '0;
        ctrl.alu_op = mips_core_pkg::alu_add;
        ctrl.branch = mips_core_pkg::br_none;
        ctrl.dest = instr.i.rt;

        case (instr.i.op)
            mips_isa_pkg::op_special: begin
                // R-type writes rd
                ctrl.dest = instr.r.rd;
                ctrl.reg_write = 1'b1;
                case (instr.r.funct)
                    mips_isa_pkg::fn_addu: ctrl.alu_op = mips_core_pkg::alu_add;
                    mips_isa_pkg::fn_subu: ctrl.alu_op = mips_core_pkg::alu_sub;
                    mips_isa_pkg::fn_and: ctrl.alu_op = mips_core_pkg::alu_and;
                    mips_isa_pkg::fn_or: ctrl.alu_op = mips_core_pkg::alu_or;
                    mips_isa_pkg::fn_xor: ctrl.alu_op = mips_core_pkg::alu_xor;
                    mips_isa_pkg::fn_slt: ctrl.alu_op = mips_core_pkg::alu_slt;
                    mips_isa_pkg::fn_sltu: ctrl.alu_op = mips_core_pkg::alu_sltu;
                    mips_isa_pkg::fn_sll: begin
                        ctrl.alu_op = mips_core_pkg::alu_sll;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_isa_pkg::fn_srl: begin
                        ctrl.alu_op = mips_core_pkg::alu_srl;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_isa_pkg::fn_sra: begin
                        ctrl.alu_op = mips_core_pkg::alu_sra;
                        ctrl.use_shamt = 1'b1;
                    end
                    mips_isa_pkg::fn_jr: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.is_jr = 1'b1;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti, mips_isa_pkg::op_sltiu: begin
                ctrl.src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                if (instr.i.op == mips_isa_pkg::op_slti) begin
                    ctrl.alu_op = mips_core_pkg::alu_slt;
                end else if (instr.i.op == mips_isa_pkg::op_sltiu) begin
                    ctrl.alu_op = mips_core_pkg::alu_sltu;
                end
            end
            mips_isa_pkg::op_andi, mips_isa_pkg::op_ori, mips_isa_pkg::op_xori: begin
                // Logical immediates are zero-extended
                ctrl.src_imm = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write = 1'b1;
                if (instr.i.op == mips_isa_pkg::op_andi) begin
                    ctrl.alu_op = mips_core_pkg::alu_and;
                end else if (instr.i.op == mips_isa_pkg::op_ori) begin
                    ctrl.alu_op = mips_core_pkg::alu_or;
                end else begin
                    ctrl.alu_op = mips_core_pkg::alu_xor;
                end
            end
            mips_isa_pkg::op_lui: begin
                ctrl.alu_op = mips_core_pkg::alu_lui;
                ctrl.src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            mips_isa_pkg::op_lw: begin
                // Address is rs plus offset
                ctrl.src_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.is_load = 1'b1;
            end
            mips_isa_pkg::op_sw: begin
                ctrl.src_imm = 1'b1;
                ctrl.is_store = 1'b1;
            end
            mips_isa_pkg::op_beq: ctrl.branch = mips_core_pkg::br_beq;
            mips_isa_pkg::op_bne: ctrl.branch = mips_core_pkg::br_bne;
            mips_isa_pkg::op_j: ctrl.is_jump = 1'b1;
            default: ctrl.reg_write = 1'b0;
        endcase
    end

endmodule

//--- rtl/mips_alu.sv
// **************************************
// Integer ALU
// Add, subtract, logic, compare, shift
// by shamt and LUI; also forms LW/SW
// addresses
// **************************************

`timescale 1ns/1ps

module mips_alu (
    input  mips_core_pkg::ctrl_t ctrl,
    input  mips_isa_pkg::instr_u instr,
    input  mips_isa_pkg::word_t rs_value,
    input  mips_isa_pkg::word_t rt_value,
    output mips_isa_pkg::word_t result
);

    mips_isa_pkg::word_t imm_ext;
    mips_isa_pkg::word_t op_a;
    mips_isa_pkg::word_t op_b;

    // Sign extension unless a logical immediate
    assign imm_ext = ctrl.imm_zero_ext ? {16'b0, instr.i.imm}
                                       : {{16{instr.i.imm[15]}}, instr.i.imm};

    // Shifts operate on rt
    assign op_a = ctrl.use_shamt ? rt_value : rs_value;
    assign op_b = ctrl.src_imm ? imm_ext : rt_value;

    always_comb begin
        case (ctrl.alu_op)
            mips_core_pkg::alu_sub: result = op_a - op_b;
            mips_core_pkg::alu_and: result = op_a & op_b;
            mips_core_pkg::alu_or: result = op_a | op_b;
            mips_core_pkg::alu_xor: result = op_a ^ op_b;
            mips_core_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
            mips_core_pkg::alu_sltu: result = {31'b0, op_a < op_b};
            mips_core_pkg::alu_sll: result = op_a << instr.r.shamt;
            mips_core_pkg::alu_srl: result = op_a >> instr.r.shamt;
            mips_core_pkg::alu_sra: result = $signed(op_a) >>> instr.r.shamt;
            // Immediate into the upper half
            mips_core_pkg::alu_lui: result = {instr.i.imm, 16'b0};
            default: result = op_a + op_b;
        endcase
    end

endmodule

//--- rtl/mips_core_pkg.sv
// **************************************
// Core-internal types of the MIPS core
// Decoded control bundle, FSM states,
// bus request and register write-back
// **************************************

package mips_core_pkg;

    // ALU operation selected by the decoder
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    // Conditional branch kind
    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne
    } branch_t;

    // Decoded micro-op for one instruction
    typedef struct packed {
        alu_op_t alu_op;
        logic src_imm;
        logic imm_zero_ext;
        mips_isa_pkg::reg_idx_t dest;
        logic reg_write;
        logic is_load;
        logic is_store;
        branch_t branch;
        logic is_jump;
        logic is_jr;
        logic use_shamt;
    } ctrl_t;

    // Multicycle FSM states
    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_halted
    } state_t;

    // One Avalon-style access, held while waitrequest is high
    typedef struct packed {
        mips_isa_pkg::word_t address;
        logic read;
        logic write;
        mips_isa_pkg::word_t writedata;
    } bus_req_t;

    // Register file write port
    typedef struct packed {
        logic enable;
        mips_isa_pkg::reg_idx_t index;
        mips_isa_pkg::word_t data;
    } reg_wb_t;

    // Boot ROM address of MIPS I
    localparam mips_isa_pkg::word_t default_reset_vector = 32'hBFC0_0000;

endpackage

//--- rtl/mips_isa_pkg.sv
// **************************************
// MIPS I instruction set definitions
// Opcode and function encodings, field
// views and the fetched-word union used
// by the decoder and datapath units
// **************************************

package mips_isa_pkg;

    // Register index and data word
    typedef logic [4:0] reg_idx_t;
    typedef logic [31:0] word_t;

    // Major opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'd0,
        op_j = 6'd2,
        op_beq = 6'd4,
        op_bne = 6'd5,
        op_addiu = 6'd9,
        op_slti = 6'd10,
        op_sltiu = 6'd11,
        op_andi = 6'd12,
        op_ori = 6'd13,
        op_xori = 6'd14,
        op_lui = 6'd15,
        op_lw = 6'd35,
        op_sw = 6'd43
    } opcode_t;

    // Function codes under op_special
    typedef enum logic [5:0] {
        fn_sll = 6'd0,
        fn_srl = 6'd2,
        fn_sra = 6'd3,
        fn_jr = 6'd8,
        fn_addu = 6'd33,
        fn_subu = 6'd35,
        fn_and = 6'd36,
        fn_or = 6'd37,
        fn_xor = 6'd38,
        fn_slt = 6'd42,
        fn_sltu = 6'd43
    } funct_t;

    // R format
    typedef struct packed {
        opcode_t op;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_t funct;
    } r_fields_t;

    // I format, immediate or address offset
    typedef struct packed {
        opcode_t op;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [15:0] imm;
    } i_fields_t;

    // J format, word-aligned jump target
    typedef struct packed {
        opcode_t op;
        logic [25:0] target;
    } j_fields_t;

    // Same 32 bits seen through each format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_u;

    // Registers with a fixed role
    localparam reg_idx_t reg_zero = 5'd0;
    localparam reg_idx_t reg_v0 = 5'd2;

endpackage
